// File: all.f
rtl/inv_pkg.sv
rtl/inv_matrix_store.sv
rtl/inv_pivot_decode.sv
rtl/inv_row_execute.sv
rtl/inv_sequencer.sv
rtl/inv_result_stream.sv
rtl/inv_matrix_top.sv
dv/inv_matrix_props.sv
dv/inv_matrix_tb.sv

// File: Bender.yml
package:
  name: inv_matrix

sources:
  - rtl/inv_pkg.sv
  - rtl/inv_matrix_store.sv
  - rtl/inv_pivot_decode.sv
  - rtl/inv_row_execute.sv
  - rtl/inv_sequencer.sv
  - rtl/inv_result_stream.sv
  - rtl/inv_matrix_top.sv
  - target: test
    files:
      - dv/inv_matrix_props.sv
      - dv/inv_matrix_tb.sv

// File: dv/inv_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module inv_matrix_tb import inv_pkg::*; ();

	localparam int NUM_TESTS  = 8;
	localparam int RST_CYCLES = 5;
	localparam int RUN_CYCLES = 60;            // load, start and a full run fit in this
	localparam int DONE_CYC   = 6 * MAT_N + 1 + (MAT_N - 1);  // columns, stream_go, rows
	localparam logic [31:0] SEED = 32'h3d7a6a1e;

	logic                 clk;
	logic                 rst_n;
	logic                 load_en;
	logic [ROW_IDX_W-1:0] load_row;
	logic [LOAD_W-1:0]    load_data;
	logic                 start;
	logic                 busy;
	logic                 singular;
	logic                 done;
	logic                 out_valid;
	logic [ROW_IDX_W-1:0] out_row;
	logic [ROW_W-1:0]     out_data;

	logic [WORD_W-1:0]          tbl_a [NUM_TESTS][MAT_N][MAT_N];  // matrix A per test
	logic                       tbl_sing [NUM_TESTS];             // expected singular
	logic                       tbl_restart [NUM_TESTS];          // extra start mid-run
	logic [4*MAT_N*MAT_N-1:0]   fixed_mat [5];                    // signed nibbles with row 0 first
	logic [WORD_W-1:0]          res [MAT_N][AUG_COLS];            // collected output rows
	int                         err_cnt;
	int                         bad_tests;

	inv_matrix_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_row  (load_row),
		.load_data (load_data),
		.start     (start),
		.busy      (busy),
		.singular  (singular),
		.done      (done),
		.out_valid (out_valid),
		.out_row   (out_row),
		.out_data  (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial
	begin
		repeat (RST_CYCLES + NUM_TESTS * RUN_CYCLES) @(posedge clk);
		$display("timeout: the DUT never finished the test sequence");
		$display("Some tests failed");
		$finish;
	end

	task automatic check_val(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	function automatic logic [WORD_W-1:0] fixed_entry(input logic [4*MAT_N*MAT_N-1:0] m,
		input int r, input int c);
		logic [3:0] n;
		n = m[((MAT_N - 1 - r) * MAT_N + (MAT_N - 1 - c)) * 4 +: 4];
		return {{(WORD_W - 4){n[3]}}, n};  // sign extend
	endfunction

	//////////////////////////////////////////////////////////////////////
	// random nonsingular A as a unit lower-triangular matrix with rows shuffled
	task automatic make_random(input int t);
		logic [WORD_W-1:0] l [MAT_N][MAT_N];
		int                perm [MAT_N];
		int                j;
		int                tmp;
		for (int r = 0; r < MAT_N; r++)
		begin
			perm[r] = r;
			for (int c = 0; c < MAT_N; c++)
				l[r][c] = (c < r) ? WORD_W'($urandom % 5) - 32'd2 : WORD_W'(c == r);
		end
		for (int r = MAT_N - 1; r > 0; r--)
		begin
			j       = $urandom % (r + 1);  // fisher-yates
			tmp     = perm[r];
			perm[r] = perm[j];
			perm[j] = tmp;
		end
		for (int r = 0; r < MAT_N; r++)
			for (int c = 0; c < MAT_N; c++)
				tbl_a[t][r][c] = l[perm[r]][c];
	endtask

	task automatic build_table();
		fixed_mat[0] = {20'h10001, 20'h01300, 20'h00100, 20'h01010, 20'h00001};  // reference
		fixed_mat[1] = {20'h10000, 20'h01000, 20'h00100, 20'h00010, 20'h00001};  // identity
		fixed_mat[2] = {20'h01000, 20'h00100, 20'h10000, 20'h00001, 20'h00010};  // forces swaps
		fixed_mat[3] = {20'h10001, 20'h01300, 20'h00100, 20'h01300, 20'h00001};  // row 3 = row 1
		fixed_mat[4] = {20'h10000, 20'h01000, 20'h11010, 20'h00010, 20'h00001};  // column 2 zero
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			tbl_sing[t]    = (t == 3) || (t == 4);
			tbl_restart[t] = (t == 7);
			if (t < 5)
			begin
				for (int r = 0; r < MAT_N; r++)
					for (int c = 0; c < MAT_N; c++)
						tbl_a[t][r][c] = fixed_entry(fixed_mat[t], r, c);
			end
			else
				make_random(t);  // test 5 also follows a singular run
		end
	endtask

	// left half diagonal and R*A equal to it mod 2^32
	task automatic check_product(input int t);
		logic [WORD_W-1:0] acc;
		for (int i = 0; i < MAT_N; i++)
		begin
			for (int j = 0; j < MAT_N; j++)
			begin
				acc = '0;
				for (int k = 0; k < MAT_N; k++)
					acc = acc + res[i][MAT_N + k] * tbl_a[t][k][j];
				check_val("out_data R*A", acc, res[i][j]);
				if (i == j)
					check_val("out_data diag nonzero", res[i][i] != '0, 1);
				else
					check_val("out_data off-diag", res[i][j], '0);
			end
		end
	endtask

	task automatic run_test(input int t);
		int   n_rows;
		int   cyc;
		int   errs_before;
		logic seen_done;
		errs_before = err_cnt;
		for (int r = 0; r < MAT_N; r++)
		begin
			@(negedge clk);
			load_en  = 1'b1;
			load_row = ROW_IDX_W'(r);
			for (int c = 0; c < MAT_N; c++)
				load_data[c*WORD_W +: WORD_W] = tbl_a[t][r][c];
		end
		@(negedge clk);
		load_en = 1'b0;
		start   = 1'b1;
		@(negedge clk);
		start     = 1'b0;
		n_rows    = 0;
		cyc       = 0;
		seen_done = 1'b0;
		while (!seen_done)
		begin
			if (out_valid)
			begin
				check_val("out_row", out_row, n_rows);            // rows in order and once each
				check_val("done", done, n_rows == MAT_N - 1);     // done with the last row
				if (n_rows < MAT_N)
					for (int k = 0; k < AUG_COLS; k++)
						res[n_rows][k] = out_data[k*WORD_W +: WORD_W];
				n_rows++;
			end
			if (done)
			begin
				seen_done = 1'b1;
				if (!tbl_sing[t])
					check_val("done latency", cyc, DONE_CYC);  // a restart would stretch the run
			end
			else
			begin
				if (tbl_restart[t] && (cyc == 3))
				begin
					check_val("busy", busy, 1);
					start = 1'b1;  // must be ignored
				end
				else
					start = 1'b0;
				cyc++;
				@(negedge clk);
			end
		end
		if (tbl_restart[t])
			start = 1'b1;  // lands on the last busy cycle and must be dropped
		@(negedge clk);
		start = 1'b0;
		check_val("busy", busy, 0);  // busy falls right after done
		check_val("singular", singular, tbl_sing[t]);
		check_val("row count", n_rows, tbl_sing[t] ? 0 : MAT_N);
		if (!tbl_sing[t] && (n_rows == MAT_N))
			check_product(t);
		$display("test %0d: %s", t, (err_cnt == errs_before) ? "ok" : "errors");
		if (err_cnt != errs_before)
			bad_tests++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		rst_n     = 1'b0;
		load_en   = 1'b0;
		load_row  = '0;
		load_data = '0;
		start     = 1'b0;
		err_cnt   = 0;
		bad_tests = 0;
		void'($urandom(SEED));
		build_table();
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_val("busy", busy, 0);
		check_val("done", done, 0);
		check_val("out_valid", out_valid, 0);
		check_val("singular", singular, 0);
		$display("reset: %s", (err_cnt == 0) ? "ok" : "errors");
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests run: %0d, tests with errors: %0d, failed checks: %0d",
			NUM_TESTS, bad_tests, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/inv_matrix_props.sv
`timescale 1ns/1ps
`default_nettype none

module inv_matrix_props (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic singular,
	input logic done,
	input logic out_valid
);

	//////////////////////////////////////////////////////////////////////
	// output protocol of the inverter
	done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// rows only come out of a run that was already under way
	valid_inside_run: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> $past(busy))
		else $error("out_valid rose outside a run");

	// singular stays up until the next start so no row may show up under it
	no_rows_when_singular: assert property (@(posedge clk) disable iff (!rst_n)
		singular |-> !out_valid)
		else $error("out_valid seen in a singular run");

	// a start inside a run neither ends it early nor opens a new one after done
	start_ignored_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(start && busy) |=> (busy == !$past(done)))
		else $error("start during a run changed busy");

endmodule

bind inv_matrix_top inv_matrix_props props_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.start     (start),
	.busy      (busy),
	.singular  (singular),
	.done      (done),
	.out_valid (out_valid)
);

`default_nettype wire

// File: rtl/inv_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module inv_matrix_top import inv_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load_en,
	input  logic [ROW_IDX_W-1:0] load_row,
	input  logic [LOAD_W-1:0]    load_data,
	input  logic                 start,
	output logic                 busy,
	output logic                 singular,
	output logic                 done,
	output logic                 out_valid,
	output logic [ROW_IDX_W-1:0] out_row,
	output logic [ROW_W-1:0]     out_data
);

	logic                 busy_seq;
	logic                 load_ok;      // loads and starts are dropped while busy
	logic                 start_ok;
	logic [ROW_IDX_W-1:0] col_sel;
	logic [ROW_IDX_W-1:0] piv_sel;
	logic [ROW_IDX_W-1:0] tgt_sel;
	logic [ROW_IDX_W-1:0] rd_sel;
	logic                 swap_en;
	logic [ROW_IDX_W-1:0] swap_a;
	logic [ROW_IDX_W-1:0] swap_b;
	logic                 wr_en;
	logic [ROW_IDX_W-1:0] wr_row;
	logic [ROW_W-1:0]     wr_data;
	logic [ROW_W-1:0]     piv_row_data;
	logic [ROW_W-1:0]     tgt_row_data;
	logic [ROW_W-1:0]     rd_row_data;
	logic [LOAD_W-1:0]    col_data;
	logic                 stream_go;
	logic                 fail_done;

	assign busy     = busy_seq || out_valid || done;  // covers the stream and fail tail
	assign load_ok  = load_en && !busy;
	assign start_ok = start && !busy;

	inv_matrix_store store_i (
		.clk (clk), .rst_n (rst_n),
		.load_en (load_ok), .load_row (load_row), .load_data (load_data),
		.swap_en (swap_en), .swap_a (swap_a), .swap_b (swap_b),
		.wr_en (wr_en), .wr_row (wr_row), .wr_data (wr_data),
		.col_sel (col_sel), .piv_sel (piv_sel), .tgt_sel (tgt_sel), .rd_sel (rd_sel),
		.piv_row_data (piv_row_data), .tgt_row_data (tgt_row_data),
		.rd_row_data (rd_row_data), .col_data (col_data)
	);

	inv_sequencer seq_i (
		.clk (clk), .rst_n (rst_n), .start (start_ok), .col_data (col_data),
		.piv_row_data (piv_row_data), .tgt_row_data (tgt_row_data),
		.busy_seq (busy_seq), .singular (singular),
		.col_sel (col_sel), .piv_sel (piv_sel), .tgt_sel (tgt_sel),
		.swap_en (swap_en), .swap_a (swap_a), .swap_b (swap_b),
		.wr_en (wr_en), .wr_row (wr_row), .wr_data (wr_data),
		.stream_go (stream_go), .fail_done (fail_done)
	);

	inv_result_stream stream_i (
		.clk (clk), .rst_n (rst_n), .stream_go (stream_go), .fail_done (fail_done),
		.rd_row_data (rd_row_data), .rd_sel (rd_sel), .out_valid (out_valid),
		.out_row (out_row), .out_data (out_data), .done (done)
	);

endmodule

`default_nettype wire

// File: rtl/inv_result_stream.sv
`timescale 1ns/1ps
`default_nettype none

module inv_result_stream import inv_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stream_go,    // start streaming rows 0..MAT_N-1
	input  logic                 fail_done,    // singular run ended
	input  logic [ROW_W-1:0]     rd_row_data,
	output logic [ROW_IDX_W-1:0] rd_sel,
	output logic                 out_valid,
	output logic [ROW_IDX_W-1:0] out_row,
	output logic [ROW_W-1:0]     out_data,
	output logic                 done          // with last row, or after fail_done
);

	logic                 streaming;  // rows going out
	logic [ROW_IDX_W-1:0] row_r;      // row on the output this cycle
	logic                 fail_q;     // delayed fail_done
	logic                 last_row;

	assign last_row = streaming && (row_r == ROW_IDX_W'(MAT_N - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			streaming <= 1'b0;
			row_r     <= '0;
			fail_q    <= 1'b0;
		end
		else
		begin
			fail_q <= fail_done;
			if (stream_go)
			begin
				streaming <= 1'b1;
				row_r     <= '0;
			end
			else if (last_row)
			begin
				streaming <= 1'b0;  // no hold, one row per cycle
				row_r     <= '0;
			end
			else if (streaming)
				row_r <= row_r + 1'b1;
		end
	end

	assign rd_sel    = row_r;
	assign out_valid = streaming;
	assign out_row   = row_r;
	assign out_data  = rd_row_data;    // combinational read of the store
	assign done      = last_row || fail_q;

endmodule

`default_nettype wire

// File: rtl/inv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module inv_sequencer import inv_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,         // already gated by top-level busy
	input  logic [LOAD_W-1:0]    col_data,
	input  logic [ROW_W-1:0]     piv_row_data,
	input  logic [ROW_W-1:0]     tgt_row_data,
	output logic                 busy_seq,
	output logic                 singular,      // held until next start
	output logic [ROW_IDX_W-1:0] col_sel,
	output logic [ROW_IDX_W-1:0] piv_sel,
	output logic [ROW_IDX_W-1:0] tgt_sel,
	output logic                 swap_en,
	output logic [ROW_IDX_W-1:0] swap_a,
	output logic [ROW_IDX_W-1:0] swap_b,
	output logic                 wr_en,
	output logic [ROW_IDX_W-1:0] wr_row,
	output logic [ROW_W-1:0]     wr_data,
	output logic                 stream_go,     // one cycle after last column
	output logic                 fail_done      // one cycle after a failed search
);

	logic [2:0]           state;
	logic [ROW_IDX_W-1:0] col_r;     // current column
	logic [ROW_IDX_W-1:0] tgt_r;     // row being eliminated
	logic [ROW_IDX_W-1:0] piv_r;     // pivot row found by decode
	logic [ROW_IDX_W-1:0] tgt_inc;
	logic [ROW_IDX_W-1:0] next_tgt;  // next target, diagonal row skipped
	logic                 last_tgt;
	logic                 pivot_found;
	logic [ROW_IDX_W-1:0] pivot_idx;

	inv_pivot_decode decode_i (
		.col_data    (col_data),
		.col_sel     (col_r),
		.pivot_found (pivot_found),
		.pivot_idx   (pivot_idx)
	);

	inv_row_execute execute_i (
		.piv_row_data (piv_row_data),
		.tgt_row_data (tgt_row_data),
		.col_sel      (col_r),
		.new_row      (wr_data)
	);

	assign tgt_inc  = tgt_r + 1'b1;
	assign next_tgt = (tgt_inc == col_r) ? tgt_inc + 1'b1 : tgt_inc;  // hop over pivot row
	assign last_tgt = (next_tgt >= ROW_IDX_W'(MAT_N));

	//////////////////////////////////////////////////////////////////////
	// column / row stepping, 6 cycles per column
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= ST_IDLE;
			col_r    <= '0;
			tgt_r    <= '0;
			piv_r    <= '0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state    <= ST_PIVOT;
						col_r    <= '0;
						singular <= 1'b0;  // new run clears old flag
					end
				end
				ST_PIVOT:
				begin
					if (pivot_found)
					begin
						piv_r <= pivot_idx;
						tgt_r <= (col_r == '0) ? ROW_IDX_W'(1) : '0;  // first non-pivot row
						state <= ST_SWAP;
					end
					else
					begin
						singular <= 1'b1;
						state    <= ST_FAIL;
					end
				end
				ST_SWAP: state <= ST_ELIM;
				ST_ELIM:
				begin
					if (!last_tgt)
						tgt_r <= next_tgt;
					else if (col_r == ROW_IDX_W'(MAT_N - 1))
						state <= ST_GO;  // all columns cleared
					else
					begin
						col_r <= col_r + 1'b1;
						state <= ST_PIVOT;
					end
				end
				default: state <= ST_IDLE;  // GO and FAIL last one cycle
			endcase
		end
	end

	assign busy_seq  = (state != ST_IDLE);
	assign col_sel   = col_r;
	assign piv_sel   = col_r;   // pivot sits on the diagonal after the swap
	assign tgt_sel   = tgt_r;
	assign swap_en   = (state == ST_SWAP);
	assign swap_a    = col_r;
	assign swap_b    = piv_r;
	assign wr_en     = (state == ST_ELIM);
	assign wr_row    = tgt_r;
	assign stream_go = (state == ST_GO);
	assign fail_done = (state == ST_FAIL);

endmodule

`default_nettype wire

// File: rtl/inv_row_execute.sv
`timescale 1ns/1ps
`default_nettype none

module inv_row_execute import inv_pkg::*; (
	input  logic [ROW_W-1:0]     piv_row_data,  // row on the diagonal
	input  logic [ROW_W-1:0]     tgt_row_data,  // row being cleared
	input  logic [ROW_IDX_W-1:0] col_sel,       // current column
	output logic [ROW_W-1:0]     new_row
);

	logic [WORD_W-1:0] pivot_val;             // pivot entry
	logic [WORD_W-1:0] factor_val;            // target entry in pivot column
	logic [WORD_W-1:0] scaled_tgt [AUG_COLS]; // pivot * target
	logic [WORD_W-1:0] scaled_piv [AUG_COLS]; // factor * pivot row

	assign pivot_val  = piv_row_data[col_sel*WORD_W +: WORD_W];
	assign factor_val = tgt_row_data[col_sel*WORD_W +: WORD_W];

	//////////////////////////////////////////////////////////////////////
	// fraction-free update, all ten words in parallel
	always_comb
	begin
		for (int k = 0; k < AUG_COLS; k++)
		begin
			scaled_tgt[k] = pivot_val * tgt_row_data[k*WORD_W +: WORD_W];   // mod 2^32
			scaled_piv[k] = factor_val * piv_row_data[k*WORD_W +: WORD_W];
		end
	end

	always_comb
	begin
		for (int k = 0; k < AUG_COLS; k++)
		begin
			new_row[k*WORD_W +: WORD_W] = scaled_tgt[k] - scaled_piv[k];  // zero at col_sel
		end
	end

endmodule

`default_nettype wire

// File: rtl/inv_pivot_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inv_pivot_decode import inv_pkg::*; (
	input  logic [LOAD_W-1:0]    col_data,     // current column, one word per row
	input  logic [ROW_IDX_W-1:0] col_sel,      // current column = diagonal row
	output logic                 pivot_found,
	output logic [ROW_IDX_W-1:0] pivot_idx
);

	logic [MAT_N-1:0] cand;  // usable pivot rows

	// rows above the diagonal are already pivots of earlier columns
	always_comb
	begin
		for (int r = 0; r < MAT_N; r++)
		begin
			cand[r] = (ROW_IDX_W'(r) >= col_sel) &&
				(col_data[r*WORD_W +: WORD_W] != '0);  // nonzero entry at or below diag
		end
	end

	// priority pick, lowest row index wins
	always_comb
	begin
		pivot_found = |cand;
		pivot_idx   = '0;
		for (int r = MAT_N - 1; r >= 0; r--)
		begin
			if (cand[r])
			begin
				pivot_idx = ROW_IDX_W'(r);  // later iteration = lower index overrides
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/inv_matrix_store.sv
`timescale 1ns/1ps
`default_nettype none

module inv_matrix_store import inv_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load_en,      // write one row of A
	input  logic [ROW_IDX_W-1:0] load_row,
	input  logic [LOAD_W-1:0]    load_data,
	input  logic                 swap_en,      // exchange two whole rows
	input  logic [ROW_IDX_W-1:0] swap_a,
	input  logic [ROW_IDX_W-1:0] swap_b,
	input  logic                 wr_en,        // row write-back from elimination
	input  logic [ROW_IDX_W-1:0] wr_row,
	input  logic [ROW_W-1:0]     wr_data,
	input  logic [ROW_IDX_W-1:0] col_sel,      // column read port select
	input  logic [ROW_IDX_W-1:0] piv_sel,
	input  logic [ROW_IDX_W-1:0] tgt_sel,
	input  logic [ROW_IDX_W-1:0] rd_sel,
	output logic [ROW_W-1:0]     piv_row_data,
	output logic [ROW_W-1:0]     tgt_row_data,
	output logic [ROW_W-1:0]     rd_row_data,
	output logic [LOAD_W-1:0]    col_data      // one word per row, row 0 lowest
);

	logic [ROW_W-1:0]  mat [MAT_N];  // augmented matrix, column 0 in lowest word
	logic [LOAD_W-1:0] unit_vec;     // identity row for the row being loaded

	always_comb
	begin
		for (int r = 0; r < MAT_N; r++)
		begin
			unit_vec[r*WORD_W +: WORD_W] = WORD_W'(load_row == ROW_IDX_W'(r));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// load, swap, write-back
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int r = 0; r < MAT_N; r++)
			begin
				mat[r] <= '0;
			end
		end
		else if (load_en && (load_row < ROW_IDX_W'(MAT_N)))
		begin
			mat[load_row] <= {unit_vec, load_data};  // right half gets e(load_row)
		end
		else if (swap_en)
		begin
			mat[swap_a] <= mat[swap_b];  // self-swap when pivot already in place
			mat[swap_b] <= mat[swap_a];
		end
		else if (wr_en)
		begin
			mat[wr_row] <= wr_data;
		end
	end

	// read ports
	assign piv_row_data = mat[piv_sel];
	assign tgt_row_data = mat[tgt_sel];
	assign rd_row_data  = mat[rd_sel];

	always_comb
	begin
		for (int r = 0; r < MAT_N; r++)
		begin
			col_data[r*WORD_W +: WORD_W] = mat[r][col_sel*WORD_W +: WORD_W];  // column slice
		end
	end

endmodule

`default_nettype wire

// File: rtl/inv_pkg.sv
`default_nettype none

package inv_pkg;

	//////////////////////////////////////////////////////////////////////
	// matrix geometry
	localparam int MAT_N     = 5;                  // order of A
	localparam int AUG_COLS  = 2 * MAT_N;          // left half A, right half identity
	localparam int WORD_W    = 32;                 // entry width, arithmetic wraps
	localparam int ROW_IDX_W = 3;                  // row or column index
	localparam int ROW_W     = AUG_COLS * WORD_W;  // flat augmented row
	localparam int LOAD_W    = MAT_N * WORD_W;     // flat loaded row, also a flat column

	// sequencer state codes
	localparam logic [2:0] ST_IDLE  = 3'd0;        // waiting for start
	localparam logic [2:0] ST_PIVOT = 3'd1;        // search current column
	localparam logic [2:0] ST_SWAP  = 3'd2;        // bring pivot row onto the diagonal
	localparam logic [2:0] ST_ELIM  = 3'd3;        // one other row per cycle
	localparam logic [2:0] ST_GO    = 3'd4;        // kick the result stream
	localparam logic [2:0] ST_FAIL  = 3'd5;        // no pivot, end the run

endpackage

`default_nettype wire
